//--- rtl/soc_ifc_pkg.sv
// Register map, widths and bus structs shared by the SoC interface block
// Every RTL and testbench file refers to these by scoped name
`default_nettype none

package soc_ifc_pkg;

    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 6;
    localparam int FUSE_WORDS = 8;
    localparam int FUSE_SEL_W = $clog2(FUSE_WORDS);

    // Word addresses
    localparam logic [ADDR_W-1:0] ADDR_FUSE_BASE      = 6'h00;
    localparam logic [ADDR_W-1:0] ADDR_FUSE_WR_DONE   = 6'h08;
    localparam logic [ADDR_W-1:0] ADDR_WDT_T1_EN      = 6'h10;
    localparam logic [ADDR_W-1:0] ADDR_WDT_T1_RESTART = 6'h11;
    localparam logic [ADDR_W-1:0] ADDR_WDT_T1_PERIOD  = 6'h12;
    localparam logic [ADDR_W-1:0] ADDR_WDT_T2_EN      = 6'h13;
    localparam logic [ADDR_W-1:0] ADDR_WDT_T2_RESTART = 6'h14;
    localparam logic [ADDR_W-1:0] ADDR_WDT_T2_PERIOD  = 6'h15;
    localparam logic [ADDR_W-1:0] ADDR_WDT_STATUS     = 6'h16;
    localparam logic [ADDR_W-1:0] ADDR_ERROR_INTR_STS = 6'h17;
    localparam logic [ADDR_W-1:0] ADDR_HW_ERROR_FATAL = 6'h18;

    typedef enum logic [4:0] {
        REG_NONE = 5'd0,
        REG_FUSE,
        REG_FUSE_WR_DONE,
        REG_WDT_T1_EN,
        REG_WDT_T1_RESTART,
        REG_WDT_T1_PERIOD,
        REG_WDT_T2_EN,
        REG_WDT_T2_RESTART,
        REG_WDT_T2_PERIOD,
        REG_WDT_STATUS,
        REG_ERROR_INTR_STS,
        REG_HW_ERROR_FATAL
    } reg_idx_t;

    // soc_req marks a request from the SoC side rather than the uC
    typedef struct packed {
        logic              req;
        logic              write;
        logic              soc_req;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } soc_ifc_req_t;

    typedef struct packed {
        logic              valid;
        logic              err;
        logic [DATA_W-1:0] rdata;
    } soc_ifc_rsp_t;

    // Decoded request, write_en already qualified by permission
    typedef struct packed {
        logic                  valid;
        reg_idx_t              idx;
        logic [FUSE_SEL_W-1:0] fuse_sel;
        logic                  write_en;
        logic                  err;
        logic [DATA_W-1:0]     wdata;
    } reg_op_t;

    typedef struct packed {
        logic              t1_en;
        logic              t2_en;
        logic              t1_restart;
        logic              t2_restart;
        logic [DATA_W-1:0] t1_period;
        logic [DATA_W-1:0] t2_period;
    } wdt_cfg_t;

    typedef struct packed {
        logic t2_timeout;
        logic t1_timeout;
    } wdt_status_t;

endpackage

`default_nettype wire

//--- rtl/soc_ifc_req_decode.sv
// Request decoder for the SoC interface registers
// Registers each request strobe as a decoded operation with write permission applied
`timescale 1ns/1ps
`default_nettype none

module soc_ifc_req_decode (
    input  wire                       clk,
    input  wire                       cptra_rst_b,
    input  wire soc_ifc_pkg::soc_ifc_req_t req_i,
    input  wire                       fuse_done_i,
    output soc_ifc_pkg::reg_op_t      op_o
);

    soc_ifc_pkg::reg_op_t           op_d;
    logic [soc_ifc_pkg::ADDR_W-1:0] fuse_off;
    logic                           refuse;

    assign fuse_off = req_i.addr - soc_ifc_pkg::ADDR_FUSE_BASE;

    always_comb begin
        op_d          = '0;
        op_d.valid    = req_i.req;
        op_d.wdata    = req_i.wdata;
        op_d.idx      = soc_ifc_pkg::REG_NONE;
        op_d.fuse_sel = fuse_off[soc_ifc_pkg::FUSE_SEL_W-1:0];

        // Address map
        if (fuse_off < soc_ifc_pkg::FUSE_WORDS) begin
            op_d.idx = soc_ifc_pkg::REG_FUSE;
        end else begin
            case (req_i.addr)
                soc_ifc_pkg::ADDR_FUSE_WR_DONE:   op_d.idx = soc_ifc_pkg::REG_FUSE_WR_DONE;
                soc_ifc_pkg::ADDR_WDT_T1_EN:      op_d.idx = soc_ifc_pkg::REG_WDT_T1_EN;
                soc_ifc_pkg::ADDR_WDT_T1_RESTART: op_d.idx = soc_ifc_pkg::REG_WDT_T1_RESTART;
                soc_ifc_pkg::ADDR_WDT_T1_PERIOD:  op_d.idx = soc_ifc_pkg::REG_WDT_T1_PERIOD;
                soc_ifc_pkg::ADDR_WDT_T2_EN:      op_d.idx = soc_ifc_pkg::REG_WDT_T2_EN;
                soc_ifc_pkg::ADDR_WDT_T2_RESTART: op_d.idx = soc_ifc_pkg::REG_WDT_T2_RESTART;
                soc_ifc_pkg::ADDR_WDT_T2_PERIOD:  op_d.idx = soc_ifc_pkg::REG_WDT_T2_PERIOD;
                soc_ifc_pkg::ADDR_WDT_STATUS:     op_d.idx = soc_ifc_pkg::REG_WDT_STATUS;
                soc_ifc_pkg::ADDR_ERROR_INTR_STS: op_d.idx = soc_ifc_pkg::REG_ERROR_INTR_STS;
                soc_ifc_pkg::ADDR_HW_ERROR_FATAL: op_d.idx = soc_ifc_pkg::REG_HW_ERROR_FATAL;
                default:                          op_d.idx = soc_ifc_pkg::REG_NONE;
            endcase
        end

        // Fuses lock once done is set, and only the SoC may set done
        case (op_d.idx)
            soc_ifc_pkg::REG_NONE:         refuse = 1'b1;
            soc_ifc_pkg::REG_FUSE:         refuse = req_i.write & fuse_done_i;
            soc_ifc_pkg::REG_FUSE_WR_DONE: refuse = req_i.write & (~req_i.soc_req | fuse_done_i);
            default:                       refuse = 1'b0;
        endcase

        op_d.err      = req_i.req & refuse;
        op_d.write_en = req_i.req & req_i.write & ~refuse;

        // Status is read only; drop the write quietly so it answers with zero data
        if (req_i.write && op_d.idx == soc_ifc_pkg::REG_WDT_STATUS) begin
            op_d.write_en = 1'b0;
            op_d.idx      = soc_ifc_pkg::REG_NONE;
        end
    end

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            op_o <= '0;
        end else begin
            op_o <= op_d;
        end
    end

endmodule

`default_nettype wire

//--- rtl/soc_ifc_regfile.sv
// Register file for fuses, watchdog configuration and error reporting
// Applies decoded writes and returns one registered response per operation
`timescale 1ns/1ps
`default_nettype none

module soc_ifc_regfile (
    input  wire                          clk,
    input  wire                          cptra_rst_b,
    input  wire soc_ifc_pkg::reg_op_t    op_i,
    input  wire soc_ifc_pkg::wdt_status_t wdt_status_i,
    output soc_ifc_pkg::soc_ifc_rsp_t    rsp_o,
    output logic                         fuse_done_o,
    output soc_ifc_pkg::wdt_cfg_t        wdt_cfg_o,
    output logic                         t1_serviced_o,
    output logic                         t2_serviced_o,
    output logic                         error_intr_o,
    output logic                         cptra_error_fatal_o,
    output logic                         nmi_intr_o
);

    logic [soc_ifc_pkg::FUSE_WORDS-1:0][soc_ifc_pkg::DATA_W-1:0] fuse_q;
    logic                           fuse_done_q;
    logic                           t1_en_q;
    logic                           t2_en_q;
    logic [soc_ifc_pkg::DATA_W-1:0] t1_period_q;
    logic [soc_ifc_pkg::DATA_W-1:0] t2_period_q;
    logic [1:0]                     intr_sts_q;
    logic [1:0]                     intr_clr;
    logic                           fatal_q;
    logic                           fatal_cond;
    logic                           t1_timeout_f;
    logic                           t2_timeout_f;
    logic [soc_ifc_pkg::DATA_W-1:0] rdata_d;

    function automatic logic wr_to(input soc_ifc_pkg::reg_idx_t idx);
        return op_i.valid & op_i.write_en & (op_i.idx == idx);
    endfunction

    function automatic logic [soc_ifc_pkg::DATA_W-1:0] zext(input logic [1:0] bits);
        logic [soc_ifc_pkg::DATA_W-1:0] word;
        word      = '0;
        word[1:0] = bits;
        return word;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Software writable storage

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            fuse_q      <= '0;
            fuse_done_q <= 1'b0;
            t1_en_q     <= 1'b0;
            t2_en_q     <= 1'b0;
            t1_period_q <= '0;
            t2_period_q <= '0;
        end else begin
            if (wr_to(soc_ifc_pkg::REG_FUSE)) fuse_q[op_i.fuse_sel] <= op_i.wdata;
            if (wr_to(soc_ifc_pkg::REG_FUSE_WR_DONE)) fuse_done_q <= op_i.wdata[0];
            if (wr_to(soc_ifc_pkg::REG_WDT_T1_EN)) t1_en_q <= op_i.wdata[0];
            if (wr_to(soc_ifc_pkg::REG_WDT_T2_EN)) t2_en_q <= op_i.wdata[0];
            if (wr_to(soc_ifc_pkg::REG_WDT_T1_PERIOD)) t1_period_q <= op_i.wdata;
            if (wr_to(soc_ifc_pkg::REG_WDT_T2_PERIOD)) t2_period_q <= op_i.wdata;
        end
    end

    assign fuse_done_o          = fuse_done_q;
    assign wdt_cfg_o.t1_en      = t1_en_q;
    assign wdt_cfg_o.t2_en      = t2_en_q;
    assign wdt_cfg_o.t1_period  = t1_period_q;
    assign wdt_cfg_o.t2_period  = t2_period_q;
    // Restart registers hold nothing, a write of 1 is a one-cycle strobe
    assign wdt_cfg_o.t1_restart = wr_to(soc_ifc_pkg::REG_WDT_T1_RESTART) & op_i.wdata[0];
    assign wdt_cfg_o.t2_restart = wr_to(soc_ifc_pkg::REG_WDT_T2_RESTART) & op_i.wdata[0];

    ////////////////////////////////////////////////////////////////////////////
    // Error interrupt status and fatal error

    assign intr_clr      = {2{wr_to(soc_ifc_pkg::REG_ERROR_INTR_STS)}} & op_i.wdata[1:0];
    assign t1_serviced_o = intr_clr[0];
    assign t2_serviced_o = intr_clr[1];

    // Cascaded mode is t2 disabled, so a t2 timeout there is fatal
    assign fatal_cond          = wdt_status_i.t2_timeout & ~t2_en_q;
    assign cptra_error_fatal_o = fatal_cond;
    assign nmi_intr_o          = fatal_cond;
    assign error_intr_o        = |intr_sts_q;

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            t1_timeout_f <= 1'b0;
            t2_timeout_f <= 1'b0;
            intr_sts_q   <= '0;
            fatal_q      <= 1'b0;
        end else begin
            t1_timeout_f  <= wdt_status_i.t1_timeout;
            t2_timeout_f  <= wdt_status_i.t2_timeout;
            // Set on a rising timeout wins over a clear in the same cycle
            intr_sts_q[0] <= (intr_sts_q[0] & ~intr_clr[0])
                           | (wdt_status_i.t1_timeout & ~t1_timeout_f);
            intr_sts_q[1] <= (intr_sts_q[1] & ~intr_clr[1])
                           | (wdt_status_i.t2_timeout & ~t2_timeout_f & t2_en_q);
            fatal_q       <= (fatal_q & ~(wr_to(soc_ifc_pkg::REG_HW_ERROR_FATAL)
                           & op_i.wdata[0])) | fatal_cond;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read mux and response

    always_comb begin
        case (op_i.idx)
            soc_ifc_pkg::REG_FUSE:           rdata_d = fuse_q[op_i.fuse_sel];
            soc_ifc_pkg::REG_FUSE_WR_DONE:   rdata_d = zext({1'b0, fuse_done_q});
            soc_ifc_pkg::REG_WDT_T1_EN:      rdata_d = zext({1'b0, t1_en_q});
            soc_ifc_pkg::REG_WDT_T1_PERIOD:  rdata_d = t1_period_q;
            soc_ifc_pkg::REG_WDT_T2_EN:      rdata_d = zext({1'b0, t2_en_q});
            soc_ifc_pkg::REG_WDT_T2_PERIOD:  rdata_d = t2_period_q;
            soc_ifc_pkg::REG_WDT_STATUS:     rdata_d = zext(wdt_status_i);
            soc_ifc_pkg::REG_ERROR_INTR_STS: rdata_d = zext(intr_sts_q);
            soc_ifc_pkg::REG_HW_ERROR_FATAL: rdata_d = zext({1'b0, fatal_q});
            default:                         rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            rsp_o <= '0;
        end else begin
            rsp_o.valid <= op_i.valid;
            rsp_o.err   <= op_i.valid & op_i.err;
            // Writes and errors answer with zero data
            rsp_o.rdata <= (op_i.valid && !op_i.write_en && !op_i.err) ? rdata_d : '0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/soc_ifc_wdt.sv
// Two-timer watchdog, independent or cascaded depending on the timer 2 enable
// Timeout flags hold until the timer is serviced, restarted or disabled
`timescale 1ns/1ps
`default_nettype none

module soc_ifc_wdt (
    input  wire                         clk,
    input  wire                         cptra_rst_b,
    input  wire soc_ifc_pkg::wdt_cfg_t  cfg_i,
    input  wire                         t1_serviced_i,
    input  wire                         t2_serviced_i,
    output soc_ifc_pkg::wdt_status_t    status_o
);

    // Index 0 is timer 1, index 1 is timer 2
    logic [1:0][soc_ifc_pkg::DATA_W-1:0] count_q;
    logic [1:0][soc_ifc_pkg::DATA_W-1:0] period;
    logic [1:0]                          timeout_q;
    logic [1:0]                          run;
    logic [1:0]                          clr;
    logic [1:0]                          svc;

    ////////////////////////////////////////////////////////////////////////////
    // Per-timer controls

    assign period = {cfg_i.t2_period, cfg_i.t1_period};

    assign run[0] = cfg_i.t1_en;
    assign clr[0] = ~cfg_i.t1_en | cfg_i.t1_restart;
    assign svc[0] = t1_serviced_i;

    // With t2 disabled, timer 2 only runs behind a timer 1 timeout
    assign run[1] = cfg_i.t2_en | timeout_q[0];
    assign clr[1] = cfg_i.t2_restart | ~run[1];
    assign svc[1] = t2_serviced_i;

    ////////////////////////////////////////////////////////////////////////////
    // Counters

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            count_q   <= '0;
            timeout_q <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (clr[i] || svc[i]) begin
                    count_q[i]   <= '0;
                    timeout_q[i] <= 1'b0;
                end else if (run[i] && !timeout_q[i]) begin
                    // Count stops at the period and the flag holds
                    if (count_q[i] >= period[i]) begin
                        timeout_q[i] <= 1'b1;
                    end else begin
                        count_q[i] <= count_q[i] + 1'b1;
                    end
                end
            end
        end
    end

    assign status_o.t1_timeout = timeout_q[0];
    assign status_o.t2_timeout = timeout_q[1];

endmodule

`default_nettype wire

//--- rtl/soc_ifc_top.sv
// Top level of the reduced SoC interface block
// Decoder feeds the register file, which configures the watchdog and reports errors
`timescale 1ns/1ps
`default_nettype none

module soc_ifc_top (
    input  wire                            clk,
    input  wire                            cptra_rst_b,
    input  wire soc_ifc_pkg::soc_ifc_req_t req_i,
    output soc_ifc_pkg::soc_ifc_rsp_t      rsp_o,
    output logic                           fuse_done_o,
    output logic                           error_intr_o,
    output logic                           cptra_error_fatal_o,
    output logic                           nmi_intr_o
);

    soc_ifc_pkg::reg_op_t     op;
    soc_ifc_pkg::wdt_cfg_t    wdt_cfg;
    soc_ifc_pkg::wdt_status_t wdt_status;
    logic                     fuse_done;
    logic                     t1_serviced;
    logic                     t2_serviced;

    soc_ifc_req_decode i_req_decode (
        .clk         (clk),
        .cptra_rst_b (cptra_rst_b),
        .req_i       (req_i),
        .fuse_done_i (fuse_done),
        .op_o        (op)
    );

    soc_ifc_regfile i_regfile (
        .clk                 (clk),
        .cptra_rst_b         (cptra_rst_b),
        .op_i                (op),
        .wdt_status_i        (wdt_status),
        .rsp_o               (rsp_o),
        .fuse_done_o         (fuse_done),
        .wdt_cfg_o           (wdt_cfg),
        .t1_serviced_o       (t1_serviced),
        .t2_serviced_o       (t2_serviced),
        .error_intr_o        (error_intr_o),
        .cptra_error_fatal_o (cptra_error_fatal_o),
        .nmi_intr_o          (nmi_intr_o)
    );

    soc_ifc_wdt i_wdt (
        .clk           (clk),
        .cptra_rst_b   (cptra_rst_b),
        .cfg_i         (wdt_cfg),
        .t1_serviced_i (t1_serviced),
        .t2_serviced_i (t2_serviced),
        .status_o      (wdt_status)
    );

    // Done bit also locks fuse writes in the decoder
    assign fuse_done_o = fuse_done;

endmodule

`default_nettype wire

//--- tests/soc_ifc_assertions.sv
// Concurrent checks on the SoC interface response and fatal error outputs
// Bound to soc_ifc_top from the testbench
`timescale 1ns/1ps
`default_nettype none

module soc_ifc_assertions (
    input wire                            clk,
    input wire                            cptra_rst_b,
    input wire soc_ifc_pkg::soc_ifc_req_t req_i,
    input wire soc_ifc_pkg::soc_ifc_rsp_t rsp_o,
    input wire                            cptra_error_fatal_o,
    input wire                            nmi_intr_o
);

    // A response lasts one cycle unless the next request is right behind it
    a_valid_pulse: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        (rsp_o.valid && !$past(req_i.req)) |=> !rsp_o.valid)
        else $error("rsp_o.valid stayed high without a request behind it");

    // Fixed two-cycle latency from request strobe to response
    a_rsp_latency: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        req_i.req |-> ##2 rsp_o.valid)
        else $error("rsp_o.valid missing two cycles after a request");

    // NMI and fatal error hold until a register write clears their cause
    a_nmi_held: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        ($fell(nmi_intr_o) || $fell(cptra_error_fatal_o))
            |-> ($past(req_i.req, 2) || $past(req_i.req, 3) || $past(req_i.req, 4)))
        else $error("nmi_intr_o or cptra_error_fatal_o dropped without a clearing request");

endmodule

`default_nettype wire

//--- tests/tb_soc_ifc.sv
// Testbench for the SoC interface block, driven line by line from the pattern file
// Ops per line are a write, a read with compare, a wait, a pin check or a write then read
`timescale 1ns/1ps
`default_nettype none

module tb_soc_ifc;

    localparam int MAX_LINES = 64;
    localparam int FIELDS    = 6;

    logic                      clk = 1'b0;
    logic                      cptra_rst_b = 1'b0;
    soc_ifc_pkg::soc_ifc_req_t req = '0;
    soc_ifc_pkg::soc_ifc_rsp_t rsp;
    logic                      fuse_done;
    logic                      error_intr;
    logic                      error_fatal;
    logic                      nmi_intr;

    logic [31:0] pat [0:MAX_LINES*FIELDS-1];
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    soc_ifc_top uut (
        .clk                 (clk),
        .cptra_rst_b         (cptra_rst_b),
        .req_i               (req),
        .rsp_o               (rsp),
        .fuse_done_o         (fuse_done),
        .error_intr_o        (error_intr),
        .cptra_error_fatal_o (error_fatal),
        .nmi_intr_o          (nmi_intr)
    );

    bind soc_ifc_top soc_ifc_assertions u_assertions (
        .clk                 (clk),
        .cptra_rst_b         (cptra_rst_b),
        .req_i               (req_i),
        .rsp_o               (rsp_o),
        .cptra_error_fatal_o (cptra_error_fatal_o),
        .nmi_intr_o          (nmi_intr_o)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic send(input logic write, input logic soc_req, input logic [5:0] addr,
                        input logic [31:0] wdata);
        @(posedge clk);
        req.req     <= 1'b1;
        req.write   <= write;
        req.soc_req <= soc_req;
        req.addr    <= addr;
        req.wdata   <= wdata;
    endtask

    task automatic drop_request();
        @(posedge clk);
        req.req <= 1'b0;
    endtask

    // Response is sampled on the falling edge, well away from the update
    task automatic wait_response(input string name, input logic [31:0] exp_data,
                                 input logic exp_err);
        int waited;
        waited = 1;
        @(negedge clk);
        while (!rsp.valid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (!rsp.valid) begin
            errors++;
            $display("%s: no response arrived within 4 cycles", name);
        end else begin
            check({name, " rdata"}, exp_data, rsp.rdata);
            check({name, " err"}, {31'd0, exp_err}, {31'd0, rsp.err});
        end
    endtask

    // Ends the run once the cycle budget from the patterns is used up
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run went past %0d cycles with %0d errors",
                     cycle_limit, errors);
            $display("Done: errors found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pattern sequencer

    initial begin
        int          i;
        int          line;
        int          base;
        int          waits;
        logic [31:0] op;
        logic [31:0] flag;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expv;
        logic [31:0] exp_err;
        string       name;

        for (i = 0; i < MAX_LINES * FIELDS; i++) begin
            pat[i] = '0;
        end
        $readmemh("tests/soc_ifc_patterns.txt", pat);

        // Budget is every wait plus 8 cycles per line plus 100
        line  = 0;
        waits = 0;
        while (line < MAX_LINES && pat[line*FIELDS] != 0) begin
            if (pat[line*FIELDS] == 32'd3) waits += int'(pat[line*FIELDS+3]);
            line++;
        end
        cycle_limit = waits + 8 * line + 100;

        repeat (2) @(posedge clk);
        cptra_rst_b <= 1'b1;

        line = 0;
        while (line < MAX_LINES && pat[line*FIELDS] != 0) begin
            base    = line * FIELDS;
            op      = pat[base];
            flag    = pat[base+1];
            addr    = pat[base+2];
            data    = pat[base+3];
            expv    = pat[base+4];
            exp_err = pat[base+5];
            name    = $sformatf("pattern %0d addr %02h", line + 1, addr[5:0]);
            case (op)
                32'd1: begin
                    send(1'b1, flag[0], addr[5:0], data);
                    drop_request();
                    wait_response({name, " write"}, expv, exp_err[0]);
                end
                32'd2: begin
                    send(1'b0, flag[0], addr[5:0], 32'd0);
                    drop_request();
                    wait_response({name, " read"}, expv, exp_err[0]);
                end
                32'd3: begin
                    repeat (data) @(posedge clk);
                end
                32'd4: begin
                    @(negedge clk);
                    check({name, " pins"}, expv,
                          {28'd0, nmi_intr, error_fatal, error_intr, fuse_done});
                end
                32'd5: begin
                    // Read issued the cycle right after the write
                    send(1'b1, flag[0], addr[5:0], data);
                    send(1'b0, flag[0], addr[5:0], 32'd0);
                    drop_request();
                    wait_response({name, " write"}, 32'd0, exp_err[0]);
                    wait_response({name, " read"}, expv, exp_err[0]);
                end
                default: begin
                    errors++;
                    $display("Pattern %0d has an unknown op code %0h", line + 1, op);
                end
            endcase
            line++;
        end

        $display("Summary: %0d errors over %0d patterns", errors, line);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- soc_ifc_lite.f
rtl/soc_ifc_pkg.sv
rtl/soc_ifc_req_decode.sv
rtl/soc_ifc_regfile.sv
rtl/soc_ifc_wdt.sv
rtl/soc_ifc_top.sv
tests/soc_ifc_assertions.sv
tests/tb_soc_ifc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the SoC interface testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_soc_ifc -f soc_ifc_lite.f -o tb_soc_ifc \
    && ./obj_dir/tb_soc_ifc > sim.log 2>&1 \
    || echo "Build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -q "^Done: no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tests/soc_ifc_patterns.txt
// op soc_req addr data expected exp_err; op 1 write, 2 read, 3 wait data cycles,
// 4 pins {nmi,fatal,intr,fuse_done}, 5 write then read next cycle, 0 end
// Fuse words before done, unmapped addresses
1 0 00 11111111 00000000 0
1 0 07 77777777 00000000 0
2 0 00 00000000 11111111 0
2 0 07 00000000 77777777 0
2 0 3f 00000000 00000000 1
1 0 20 12345678 00000000 1
4 0 00 00000000 00000000 0
// Fuse write done, uC refused then SoC accepted, fuses locked
1 0 08 00000001 00000000 1
2 0 08 00000000 00000000 0
4 0 00 00000000 00000000 0
1 1 08 00000001 00000000 0
2 0 08 00000000 00000001 0
4 0 00 00000000 00000001 0
1 1 00 deadbeef 00000000 1
1 0 07 cafef00d 00000000 1
2 0 00 00000000 11111111 0
2 0 07 00000000 77777777 0
1 1 08 00000000 00000000 1
2 0 08 00000000 00000001 0
// Back to back write then read
5 0 12 000000a5 000000a5 0
5 0 15 0000005a 0000005a 0
// Independent mode, t1 timeout and clear
1 0 15 ffffffff 00000000 0
1 0 13 00000001 00000000 0
1 0 12 0000000a 00000000 0
1 0 10 00000001 00000000 0
3 0 00 0000000e 00000000 0
4 0 00 00000000 00000003 0
2 0 17 00000000 00000001 0
2 0 16 00000000 00000001 0
1 0 17 00000001 00000000 0
4 0 00 00000000 00000001 0
2 0 16 00000000 00000000 0
1 0 10 00000000 00000000 0
2 0 17 00000000 00000000 0
1 0 13 00000000 00000000 0
// Cascaded mode, fatal error and NMI, then restart and clear
1 0 15 00000008 00000000 0
1 0 10 00000001 00000000 0
3 0 00 0000001c 00000000 0
4 0 00 00000000 0000000f 0
2 0 18 00000000 00000001 0
2 0 16 00000000 00000003 0
2 0 17 00000000 00000001 0
1 0 12 ffffffff 00000000 0
1 0 11 00000001 00000000 0
1 0 14 00000001 00000000 0
1 0 18 00000001 00000000 0
1 0 17 00000003 00000000 0
1 0 16 00000003 00000000 0
4 0 00 00000000 00000001 0
2 0 18 00000000 00000000 0
2 0 16 00000000 00000000 0
2 0 17 00000000 00000000 0
0 0 00 00000000 00000000 0
